/* sources.f */
tlp_core_pkg.sv
tlp_fabric_pkg.sv
tlp_pack_64to128.sv
tlp_beat_fifo.sv
tlp_unpack_128to64.sv
tlp_loopback_top.sv
tb_tlp_loopback.sv

/* Makefile */
# Verilator build and run for the TLP loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_tlp_loopback
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the simulator output itself
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

/* tb_tlp_loopback.sv */
// Directed loopback testbench; FIFO_DEPTH fixed at 8, every wait gives up after WAIT_LIMIT cycles
`timescale 1ns/1ns
`default_nettype none

module tb_tlp_loopback;
    import tlp_core_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int WAIT_LIMIT = 400;

    logic       clk_pcie;
    logic       rst;
    core_beat_t rx_beat;
    logic       rx_valid;
    logic       rx_ready;
    core_beat_t tx_beat;
    logic       tx_valid;
    logic       tx_ready;

    // Stimulus and capture flattened over all TLPs of one test
    logic [31:0] sent_dw [$];
    logic [31:0] recv_dw [$];
    int          tlp_len [$];

    int err_cnt;
    int test_cnt;
    int fail_cnt;
    bit timed_out;
    bit tx_stall;
    // Set when a presented rx beat had to wait
    bit rx_blocked;

    tlp_loopback_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .rx_beat  (rx_beat),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_beat  (tx_beat),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    initial begin
        clk_pcie = 1'b0;
        forever #20 clk_pcie = ~clk_pcie;
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_beat(input core_beat_t got, input core_beat_t exp, input string what);
        if (got.keep !== exp.keep || got.last !== exp.last) begin
            err_cnt++;
            $display("** Error at %0t ns: %s keep %h last %b, expected keep %h last %b",
                     $time, what, got.keep, got.last, exp.keep, exp.last);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_dwords();
        if (recv_dw.size() != sent_dw.size()) begin
            err_cnt++;
            $display("** Error at %0t ns: received %0d dwords, expected %0d",
                     $time, recv_dw.size(), sent_dw.size());
        end
        foreach (sent_dw[i]) begin
            if (i < recv_dw.size() && recv_dw[i] !== sent_dw[i]) begin
                err_cnt++;
                $display("** Error at %0t ns: dword %0d is %h, expected %h",
                         $time, i, recv_dw[i], sent_dw[i]);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    task automatic apply_reset();
        @(negedge clk_pcie);
        rst      = 1'b1;
        rx_valid = 1'b0;
        repeat (3) @(negedge clk_pcie);
        rst = 1'b0;
    endtask

    task automatic build_tlps(input int count, input int fixed_len);
        int len;
        sent_dw.delete();
        tlp_len.delete();
        for (int t = 0; t < count; t++) begin
            len = (fixed_len > 0) ? fixed_len : 1 + int'($urandom % 16);
            tlp_len.push_back(len);
            for (int d = 0; d < len; d++) begin
                sent_dw.push_back($urandom);
            end
        end
    endtask

    // Presents one beat and holds it until rx_ready lets it through
    task automatic drive_beat(input core_beat_t b);
        int waited;
        waited = 0;
        @(negedge clk_pcie);
        rx_beat  = b;
        rx_valid = 1'b1;
        while (!rx_ready && !timed_out) begin
            rx_blocked = 1'b1;
            @(negedge clk_pcie);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timed_out = 1'b1;
                err_cnt++;
                $display("Timeout at %0t ns: rx_ready never returned high", $time);
            end
        end
    endtask

    task automatic drive_tlps();
        core_beat_t b;
        int         base;
        int         len;
        base = 0;
        foreach (tlp_len[t]) begin
            len = tlp_len[t];
            for (int i = 0; i < len; i += 2) begin
                b.data[31:0]  = sent_dw[base + i];
                b.data[63:32] = (i + 1 < len) ? sent_dw[base + i + 1] : 32'h0;
                b.keep        = (i + 1 < len) ? KEEP_BOTH_DW : KEEP_LOW_DW;
                b.last        = (i + 2 >= len);
                drive_beat(b);
            end
            base += len;
        end
        @(negedge clk_pcie);
        rx_valid = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Monitor
    // ----------------------------------------------------------------------

    task automatic collect_tlps();
        core_beat_t exp;
        int         waited;
        int         beats;
        int         idx;
        int         cyc;
        cyc    = 0;
        waited = 0;
        foreach (tlp_len[t]) begin
            beats = (tlp_len[t] + 1) / 2;
            idx   = 0;
            while (idx < beats && !timed_out) begin
                @(negedge clk_pcie);
                cyc++;
                // Hard stall early on fills the FIFO before random toggling
                if (tx_stall && (cyc < 30 || $urandom % 2 == 0)) begin
                    tx_ready = 1'b0;
                end else begin
                    tx_ready = 1'b1;
                end
                if (tx_valid && tx_ready) begin
                    exp.data = '0;
                    exp.keep = (2 * idx + 1 == tlp_len[t]) ? KEEP_LOW_DW : KEEP_BOTH_DW;
                    exp.last = (idx == beats - 1);
                    check_beat(tx_beat, exp, $sformatf("tlp %0d beat %0d", t, idx));
                    recv_dw.push_back(tx_beat.data[31:0]);
                    if (tx_beat.keep == KEEP_BOTH_DW) begin
                        recv_dw.push_back(tx_beat.data[63:32]);
                    end
                    idx++;
                    waited = 0;
                end else begin
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        timed_out = 1'b1;
                        err_cnt++;
                        $display("Timeout at %0t ns: no tx beat arrived", $time);
                    end
                end
            end
        end
        tx_ready = 1'b1;
    endtask

    task automatic run_traffic(input int count, input int fixed_len, input bit stall,
                               input bit reuse);
        if (!reuse) begin
            build_tlps(count, fixed_len);
        end
        recv_dw.delete();
        tx_stall   = stall;
        rx_blocked = 1'b0;
        fork
            drive_tlps();
            collect_tlps();
        join
        repeat (2) @(negedge clk_pcie);
        check_dwords();
        check_flag(tx_valid, 1'b0, "tx_valid after the final TLP");
    endtask

    task automatic report_test(input string name, input int start_err);
        test_cnt++;
        if (err_cnt > start_err) begin
            fail_cnt++;
        end
        $display("%-16s %s (%0d errors)", name, (err_cnt > start_err) ? "failed" : "passed",
                 err_cnt - start_err);
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic test_odd_len();
        int e0;
        e0 = err_cnt;
        run_traffic(1, 3, 1'b0, 1'b0);
        report_test("odd_len_3dw", e0);
    endtask

    task automatic test_even_len();
        int e0;
        e0 = err_cnt;
        run_traffic(1, 4, 1'b0, 1'b0);
        report_test("even_len_4dw", e0);
    endtask

    task automatic test_random_len();
        int e0;
        e0 = err_cnt;
        run_traffic(10, 0, 1'b0, 1'b0);
        report_test("random_len", e0);
    endtask

    // Same TLPs as the random test with a stalling tx side
    task automatic test_back_pressure();
        int e0;
        e0 = err_cnt;
        run_traffic(10, 0, 1'b1, 1'b1);
        check_flag(rx_blocked, 1'b1, "rx_ready low during fill");
        report_test("back_pressure", e0);
    endtask

    task automatic test_reset();
        core_beat_t b;
        int         e0;
        e0 = err_cnt;
        apply_reset();
        check_flag(tx_valid, 1'b0, "tx_valid after reset");
        check_flag(rx_ready, 1'b1, "rx_ready after reset");
        b.data = {$urandom, $urandom};
        b.keep = KEEP_BOTH_DW;
        b.last = 1'b0;
        // One full fabric beat in the FIFO and half a beat left in the packer
        drive_beat(b);
        drive_beat(b);
        drive_beat(b);
        apply_reset();
        check_flag(tx_valid, 1'b0, "tx_valid after mid-TLP reset");
        run_traffic(1, 5, 1'b0, 1'b0);
        report_test("reset_mid_tlp", e0);
    endtask

    initial begin
        rst          = 1'b1;
        rx_valid     = 1'b0;
        rx_beat.data = '0;
        rx_beat.keep = KEEP_BOTH_DW;
        rx_beat.last = 1'b0;
        tx_ready     = 1'b1;
        err_cnt      = 0;
        test_cnt     = 0;
        fail_cnt     = 0;
        timed_out    = 1'b0;
        tx_stall     = 1'b0;
        rx_blocked   = 1'b0;
        void'($urandom(32'hc3e1_87d1));
        repeat (3) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;

        test_odd_len();
        test_even_len();
        test_random_len();
        test_back_pressure();
        test_reset();

        $display("tests run %0d, failing %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tlp_loopback_top.sv */
// Loops the core rx stream back to tx through a 128-bit fabric FIFO; single clock, no TLP checks
`timescale 1ns/1ns
`default_nettype none

module tlp_loopback_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                           clk_pcie,
    input  wire                           rst,
    input  wire tlp_core_pkg::core_beat_t rx_beat,
    input  wire                           rx_valid,
    output logic                          rx_ready,
    output tlp_core_pkg::core_beat_t      tx_beat,
    output logic                          tx_valid,
    input  wire                           tx_ready
);
    import tlp_fabric_pkg::*;

    // ----------------------------------------------------------------------
    // Fabric side links
    // ----------------------------------------------------------------------

    fab_beat_t pack_beat;
    logic      pack_valid;
    fab_beat_t fifo_beat;
    logic      fifo_valid;
    logic      fifo_ready;
    logic      fifo_room;

    tlp_pack_64to128 u_pack (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .rx_beat    (rx_beat),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .fifo_room  (fifo_room),
        .pack_beat  (pack_beat),
        .pack_valid (pack_valid)
    );

    tlp_beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_pcie  (clk_pcie),
        .rst       (rst),
        .wr_beat   (pack_beat),
        .wr_valid  (pack_valid),
        .fifo_room (fifo_room),
        .rd_beat   (fifo_beat),
        .rd_valid  (fifo_valid),
        .rd_ready  (fifo_ready)
    );

    tlp_unpack_128to64 u_unpack (
        .clk_pcie  (clk_pcie),
        .rst       (rst),
        .fab_beat  (fifo_beat),
        .fab_valid (fifo_valid),
        .fab_ready (fifo_ready),
        .tx_beat   (tx_beat),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

endmodule

`default_nettype wire

/* tlp_unpack_128to64.sv */
// Unpacks fabric beats to core beats; assumes dword keep bits are contiguous from dword 0
`timescale 1ns/1ns
`default_nettype none

module tlp_unpack_128to64 (
    input  wire                           clk_pcie,
    input  wire                           rst,
    input  wire tlp_fabric_pkg::fab_beat_t fab_beat,
    input  wire                           fab_valid,
    output logic                          fab_ready,
    output tlp_core_pkg::core_beat_t      tx_beat,
    output logic                          tx_valid,
    input  wire                           tx_ready
);
    import tlp_core_pkg::*;
    import tlp_fabric_pkg::*;

    unpack_state_e state;
    core_beat_t    lo_beat;
    core_beat_t    hi_beat;
    logic          hi_present;

    // Dword 2 set means the upper half carries data too
    assign hi_present = fab_beat.keep_dw[2];

    // Low half goes straight through from the FIFO head
    always_comb begin
        lo_beat.data = fab_beat.data[63:0];
        lo_beat.keep = fab_beat.keep_dw[1] ? KEEP_BOTH_DW : KEEP_LOW_DW;
        lo_beat.last = fab_beat.last && !hi_present;
    end

    assign tx_beat  = (state == UNPACK_HIGH) ? hi_beat : lo_beat;
    assign tx_valid = (state == UNPACK_HIGH) || fab_valid;

    // Pop only with the final half of the beat
    assign fab_ready = (state == UNPACK_HIGH) ? tx_ready
                                              : (fab_valid && tx_ready && !hi_present);

    // ----------------------------------------------------------------------
    // Half select FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            state <= UNPACK_LOW;
        end else begin
            case (state)
                UNPACK_LOW: begin
                    if (fab_valid && hi_present && tx_ready) begin
                        state <= UNPACK_HIGH;
                    end
                end
                UNPACK_HIGH: begin
                    if (tx_ready) begin
                        state <= UNPACK_LOW;
                    end
                end
                default: state <= UNPACK_LOW;
            endcase
        end
    end

    // Upper half captured as the low half leaves
    always_ff @(posedge clk_pcie) begin
        if (state == UNPACK_LOW && fab_valid && tx_ready) begin
            hi_beat.data <= fab_beat.data[127:64];
            hi_beat.keep <= fab_beat.keep_dw[3] ? KEEP_BOTH_DW : KEEP_LOW_DW;
            hi_beat.last <= fab_beat.last;
        end
    end

    // A stalled tx beat must not change before the core takes it
    a_tx_stable : assert property (
        @(posedge clk_pcie) disable iff (rst)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_beat))
    ) else $error("tx beat changed while stalled");

endmodule

`default_nettype wire

/* tlp_beat_fifo.sv */
// Fabric beat FIFO; FIFO_DEPTH must be a power of two of 4 or more, writes are never refused
`timescale 1ns/1ns
`default_nettype none

module tlp_beat_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                           clk_pcie,
    input  wire                           rst,
    input  wire tlp_fabric_pkg::fab_beat_t wr_beat,
    input  wire                           wr_valid,
    output logic                          fifo_room,
    output tlp_fabric_pkg::fab_beat_t     rd_beat,
    output logic                          rd_valid,
    input  wire                           rd_ready
);
    import tlp_fabric_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = AW + 1;

    fab_beat_t     mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] free_cnt;
    logic          rd_fire;

    assign rd_fire  = rd_valid && rd_ready;
    assign rd_valid = (count != '0);
    assign rd_beat  = mem[rd_ptr];

    // Two free slots cover a beat in flight in the packer plus one more
    assign free_cnt  = CW'(FIFO_DEPTH) - count;
    assign fifo_room = (free_cnt >= CW'(2));

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally at a power-of-two depth
            if (wr_valid) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            case ({wr_valid, rd_fire})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

    // Packer back-pressure has to keep the buffer from overflowing
    a_no_write_full : assert property (
        @(posedge clk_pcie) disable iff (rst)
        wr_valid |-> (count != CW'(FIFO_DEPTH))
    ) else $error("write into full beat FIFO");

endmodule

`default_nettype wire

/* tlp_pack_64to128.sv */
// Packs core beats into fabric beats; relies on fifo_room for space, a short beat must end its TLP
`timescale 1ns/1ns
`default_nettype none

module tlp_pack_64to128 (
    input  wire                        clk_pcie,
    input  wire                        rst,
    input  wire tlp_core_pkg::core_beat_t rx_beat,
    input  wire                        rx_valid,
    output logic                       rx_ready,
    input  wire                        fifo_room,
    output tlp_fabric_pkg::fab_beat_t  pack_beat,
    output logic                       pack_valid
);
    import tlp_core_pkg::*;
    import tlp_fabric_pkg::*;

    // Dwords already placed in the fabric beat, always 0 or 2 at a beat boundary
    logic [2:0] dw_cnt;
    logic [2:0] beat_dw;
    logic [2:0] next_cnt;
    logic       rx_fire;
    logic       fill_done;
    // High while the next accepted beat opens a new TLP
    logic       sop;

    // No internal stall, so the FIFO alone throttles the core
    assign rx_ready = fifo_room;
    assign rx_fire  = rx_valid && rx_ready;

    assign beat_dw   = (rx_beat.keep == KEEP_BOTH_DW) ? 3'(CORE_DW_PER_BEAT) : 3'd1;
    assign next_cnt  = dw_cnt + beat_dw;
    assign fill_done = (next_cnt >= 3'(FAB_DW_PER_BEAT)) || rx_beat.last;

    // ----------------------------------------------------------------------
    // Control state
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            dw_cnt     <= 3'd0;
            sop        <= 1'b1;
            pack_valid <= 1'b0;
        end else begin
            // One-cycle strobe after the completing core beat
            pack_valid <= rx_fire && fill_done;
            if (rx_fire) begin
                dw_cnt <= fill_done ? 3'd0 : next_cnt;
                sop    <= rx_beat.last;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Beat assembly
    // ----------------------------------------------------------------------

    // FIFO samples the finished beat on the same edge that may start the next one
    always_ff @(posedge clk_pcie) begin
        if (rx_fire) begin
            if (dw_cnt[1]) begin
                pack_beat.data[127:64] <= rx_beat.data;
            end else begin
                pack_beat.data[63:0] <= rx_beat.data;
                pack_beat.first      <= sop;
            end
            pack_beat.keep_dw <= {next_cnt > 3'd3, next_cnt > 3'd2, next_cnt > 3'd1, 1'b1};
            pack_beat.last    <= rx_beat.last;
        end
    end

    // Core side must only ever present the two known keep patterns
    a_rx_keep_legal : assert property (
        @(posedge clk_pcie) disable iff (rst)
        rx_valid |-> (rx_beat.keep inside {KEEP_LOW_DW, KEEP_BOTH_DW})
    ) else $error("illegal rx keep %h", rx_beat.keep);

endmodule

`default_nettype wire

/* tlp_fabric_pkg.sv */
// 128-bit fabric beat; dword keep bits are always filled contiguously from dword 0 upward
`default_nettype none

package tlp_fabric_pkg;

    // ----------------------------------------------------------------------
    // Fabric stream widths
    // ----------------------------------------------------------------------

    localparam int FAB_DATA_W = 128;

    // Dwords carried by a full fabric beat
    localparam int FAB_DW_PER_BEAT = 4;

    // ----------------------------------------------------------------------
    // One beat of the 128-bit TLP stream
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic [FAB_DATA_W-1:0]      data;
        // One bit per valid dword, bit 0 is the lowest dword
        logic [FAB_DW_PER_BEAT-1:0] keep_dw;
        // First beat of a TLP
        logic                       first;
        logic                       last;
    } fab_beat_t;

    // ----------------------------------------------------------------------
    // Unpacker half select
    // ----------------------------------------------------------------------

    // Which 64-bit half of the current fabric beat is on tx
    typedef enum logic {
        UNPACK_LOW  = 1'b0,
        UNPACK_HIGH = 1'b1
    } unpack_state_e;

endpackage

`default_nettype wire

/* tlp_core_pkg.sv */
// 64-bit core stream beat; only the last beat of a TLP may carry a single dword in the low half
`default_nettype none

package tlp_core_pkg;

    // ----------------------------------------------------------------------
    // Core stream widths
    // ----------------------------------------------------------------------

    localparam int CORE_DATA_W = 64;

    // Dwords carried by a full core beat
    localparam int CORE_DW_PER_BEAT = 2;

    // ----------------------------------------------------------------------
    // Byte keep encodings seen on the core stream
    // ----------------------------------------------------------------------

    // Low dword only is used for the tail of an odd-length TLP
    typedef enum logic [7:0] {
        KEEP_LOW_DW  = 8'h0f,
        KEEP_BOTH_DW = 8'hff
    } core_keep_e;

    // ----------------------------------------------------------------------
    // One beat of the core receive or transmit stream
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic [CORE_DATA_W-1:0] data;
        core_keep_e             keep;
        // Final beat of the TLP
        logic                   last;
    } core_beat_t;

endpackage

`default_nettype wire
